// File: common/alu_op_pkg.sv
`default_nettype none

package alu_op_pkg;

    // operate field of the execute request
    typedef enum logic [4:0] {
        ALU_ADD      = 5'd0,
        ALU_SUB      = 5'd1,
        ALU_RETURN_A = 5'd2,
        ALU_RETURN_B = 5'd3,
        ALU_XOR      = 5'd4,
        ALU_OR       = 5'd5,
        ALU_AND      = 5'd6,
        ALU_SLL      = 5'd7,
        ALU_SRL      = 5'd8,
        ALU_SLT      = 5'd9,
        ALU_SLTU     = 5'd10,
        ALU_MUL      = 5'd11,
        ALU_REM      = 5'd12,
        ALU_DIVU     = 5'd13,
        ALU_REMU     = 5'd14,
        ALU_DIV      = 5'd15,
        ALU_SRA      = 5'd16,
        ALU_EQ       = 5'd17,
        ALU_LOE      = 5'd18,
        ALU_LOEU     = 5'd19
    } alu_op_t;

    // first operand, anything but rs1 picks pc
    typedef enum logic [1:0] {
        SEL_A_PC  = 2'd0,
        SEL_A_RS1 = 2'd1
    } sel_a_t;

    // second operand, unlisted codes pick imm
    typedef enum logic [1:0] {
        SEL_B_IMM = 2'd0,
        SEL_B_RS2 = 2'd1,
        SEL_B_CSR = 2'd2
    } sel_b_t;

endpackage

`default_nettype wire

// File: common/exu_pkg.sv
`default_nettype none

package exu_pkg;

    localparam int XLEN    = 64;
    localparam int SHAMT_W = 6;

    typedef logic [XLEN-1:0]    xlen_t;
    typedef logic [SHAMT_W-1:0] shamt_t;

    // iteration counter, one bit wider than a shift amount
    typedef logic [SHAMT_W:0]   step_cnt_t;

    // one execute request, 330 bits
    typedef struct packed {
        xlen_t               pc;
        xlen_t               rs1;
        xlen_t               rs2;
        xlen_t               csr;
        xlen_t               imm;
        alu_op_pkg::alu_op_t operate;
        alu_op_pkg::sel_a_t  sel_a;
        alu_op_pkg::sel_b_t  sel_b;
        logic                rs1to32;
    } exu_req_t;

    typedef enum logic {
        LONG_IDLE,
        LONG_BUSY
    } long_state_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FIX
    } div_state_t;

endpackage

`default_nettype wire

// File: hw/alu/mul_iter.sv
`timescale 1ns/1ps
`default_nettype none

module mul_iter (
    input  logic           clk,
    input  logic           rst,
    input  logic           flush,
    input  logic           start,
    input  exu_pkg::xlen_t a,
    input  exu_pkg::xlen_t b,
    output logic           busy,
    output logic           done,
    output exu_pkg::xlen_t product
);
    import exu_pkg::*;

    xlen_t     mcand;
    xlen_t     mplier;
    xlen_t     acc;
    step_cnt_t cnt;
    logic      accept;

    assign accept  = start && !busy && !flush;
    assign product = acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (flush) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                // bit 0 is already handled at load
                busy <= 1'b1;
                cnt  <= step_cnt_t'(1);
            end else if (busy) begin
                cnt <= cnt + step_cnt_t'(1);
                if (cnt == step_cnt_t'(XLEN - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // shift-add datapath, low 64 bits only
    always_ff @(posedge clk) begin
        if (accept) begin
            acc    <= b[0] ? a : '0;
            mcand  <= a << 1;
            mplier <= b >> 1;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

`default_nettype wire

// File: hw/alu/div_iter.sv
`timescale 1ns/1ps
`default_nettype none

module div_iter (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                start,
    input  exu_pkg::xlen_t      a,
    input  exu_pkg::xlen_t      b,
    input  alu_op_pkg::alu_op_t op,
    output logic                busy,
    output logic                done,
    output exu_pkg::xlen_t      result
);
    import alu_op_pkg::*;
    import exu_pkg::*;

    div_state_t      state;
    step_cnt_t       cnt;

    logic            is_signed_op;
    logic            is_rem_op;
    xlen_t           abs_a;
    xlen_t           abs_b;

    xlen_t           quo;
    xlen_t           rem;
    xlen_t           divisor;
    logic            neg_quo;
    logic            neg_rem;
    logic            want_rem;
    logic            div_zero;

    logic [XLEN:0]   rem_sh;
    logic [XLEN:0]   diff;
    xlen_t           quo_fix;
    xlen_t           rem_fix;

    assign is_signed_op = (op == ALU_DIV) || (op == ALU_REM);
    assign is_rem_op    = (op == ALU_REM) || (op == ALU_REMU);

    // magnitudes; the most negative value maps onto itself as 2^63
    assign abs_a = (is_signed_op && a[XLEN-1]) ? -a : a;
    assign abs_b = (is_signed_op && b[XLEN-1]) ? -b : b;

    assign rem_sh = {rem, quo[XLEN-1]};
    assign diff   = rem_sh - {1'b0, divisor};

    // divide by zero: quotient all ones, remainder falls out as the dividend
    assign quo_fix = div_zero ? '1 : (neg_quo ? -quo : quo);
    assign rem_fix = neg_rem ? -rem : rem;

    assign busy = (state != DIV_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DIV_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else if (flush) begin
            state <= DIV_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state <= DIV_RUN;
                        cnt   <= '0;
                    end
                end
                DIV_RUN: begin
                    cnt <= cnt + step_cnt_t'(1);
                    if (cnt == step_cnt_t'(XLEN - 1)) begin
                        state <= DIV_FIX;
                    end
                end
                DIV_FIX: begin
                    done  <= 1'b1;
                    state <= DIV_IDLE;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                if (start) begin
                    quo      <= abs_a;
                    rem      <= '0;
                    divisor  <= abs_b;
                    neg_quo  <= is_signed_op && (a[XLEN-1] ^ b[XLEN-1]);
                    neg_rem  <= is_signed_op && a[XLEN-1];
                    want_rem <= is_rem_op;
                    div_zero <= (b == '0);
                end
            end
            DIV_RUN: begin
                // restore when the trial subtract goes negative
                if (!diff[XLEN]) begin
                    rem <= diff[XLEN-1:0];
                    quo <= {quo[XLEN-2:0], 1'b1};
                end else begin
                    rem <= rem_sh[XLEN-1:0];
                    quo <= {quo[XLEN-2:0], 1'b0};
                end
            end
            DIV_FIX: begin
                result <= want_rem ? rem_fix : quo_fix;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/alu/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  exu_pkg::exu_req_t req,
    output exu_pkg::xlen_t    res,
    output logic              alu_wait
);
    import alu_op_pkg::*;
    import exu_pkg::*;

    xlen_t       rs1_eff;
    xlen_t       a;
    xlen_t       b;
    shamt_t      shamt;
    logic [31:0] sra_lo;
    xlen_t       short_res;

    logic        is_mul;
    logic        is_div;
    logic        is_long;
    long_state_t state;

    logic        mul_start;
    logic        mul_busy;
    logic        mul_done;
    xlen_t       mul_product;
    logic        div_start;
    logic        div_busy;
    logic        div_done;
    xlen_t       div_result;

    logic        unit_done;
    logic        long_load;

    // operand select
    assign rs1_eff = req.rs1to32 ? {32'b0, req.rs1[31:0]} : req.rs1;
    assign a       = (req.sel_a == SEL_A_RS1) ? rs1_eff : req.pc;

    always_comb begin
        case (req.sel_b)
            SEL_B_RS2: b = req.rs2;
            SEL_B_CSR: b = req.csr;
            default:   b = req.imm;
        endcase
    end

    assign shamt  = b[SHAMT_W-1:0];
    // word form of sra, shifted in 32 bits and zero-extended
    assign sra_lo = $signed(a[31:0]) >>> shamt;

    always_comb begin
        case (req.operate)
            ALU_ADD:      short_res = a + b;
            ALU_SUB:      short_res = a - b;
            ALU_RETURN_A: short_res = a;
            ALU_RETURN_B: short_res = b;
            ALU_XOR:      short_res = a ^ b;
            ALU_OR:       short_res = a | b;
            ALU_AND:      short_res = a & b;
            ALU_SLL:      short_res = a << shamt;
            ALU_SRL:      short_res = a >> shamt;
            ALU_SLT:      short_res = xlen_t'($signed(a) < $signed(b));
            ALU_SLTU:     short_res = xlen_t'(a < b);
            ALU_SRA: begin
                if (req.rs1to32) begin
                    short_res = {32'b0, sra_lo};
                end else begin
                    short_res = $signed(a) >>> shamt;
                end
            end
            ALU_EQ:       short_res = xlen_t'(a == b);
            ALU_LOE:      short_res = xlen_t'($signed(a) >= $signed(b));
            ALU_LOEU:     short_res = xlen_t'(a >= b);
            default:      short_res = '0;
        endcase
    end

    assign is_mul  = (req.operate == ALU_MUL);
    assign is_div  = req.operate inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    assign is_long = is_mul | is_div;

    // one start per operation, only into an idle unit
    assign mul_start = (state == LONG_IDLE) && is_mul && !mul_busy && !flush;
    assign div_start = (state == LONG_IDLE) && is_div && !div_busy && !flush;

    assign unit_done = is_mul ? mul_done : div_done;
    assign long_load = (state == LONG_BUSY) && unit_done && !flush;
    assign alu_wait  = is_long && !long_load && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LONG_IDLE;
        end else if (flush) begin
            state <= LONG_IDLE;
        end else begin
            case (state)
                LONG_IDLE: begin
                    if (mul_start || div_start) begin
                        state <= LONG_BUSY;
                    end
                end
                LONG_BUSY: begin
                    if (unit_done) begin
                        state <= LONG_IDLE;
                    end
                end
                default: state <= LONG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else if (!flush) begin
            if (long_load) begin
                res <= is_mul ? mul_product : div_result;
            end else if (!is_long) begin
                res <= short_res;
            end
        end
    end

    mul_iter i_mul (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .start   (mul_start),
        .a       (a),
        .b       (b),
        .busy    (mul_busy),
        .done    (mul_done),
        .product (mul_product)
    );

    div_iter i_div (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .start  (div_start),
        .a      (a),
        .b      (b),
        .op     (req.operate),
        .busy   (div_busy),
        .done   (div_done),
        .result (div_result)
    );

endmodule

`default_nettype wire

// File: hw/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  exu_pkg::xlen_t      pc,
    input  exu_pkg::xlen_t      rs1,
    input  exu_pkg::xlen_t      rs2,
    input  exu_pkg::xlen_t      csr,
    input  exu_pkg::xlen_t      imm,
    input  alu_op_pkg::alu_op_t operate,
    input  alu_op_pkg::sel_a_t  sel_a,
    input  alu_op_pkg::sel_b_t  sel_b,
    input  logic                rs1to32,
    output exu_pkg::xlen_t      res,
    output logic                alu_wait
);
    import exu_pkg::*;

    exu_req_t req;

    // request bundle for the core
    assign req = '{
        pc:      pc,
        rs1:     rs1,
        rs2:     rs2,
        csr:     csr,
        imm:     imm,
        operate: operate,
        sel_a:   sel_a,
        sel_b:   sel_b,
        rs1to32: rs1to32
    };

    alu_core i_alu_core (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .req      (req),
        .res      (res),
        .alu_wait (alu_wait)
    );

endmodule

`default_nettype wire

// File: tb/tb_exu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu;
    import alu_op_pkg::*;
    import exu_pkg::*;

    // about 60 long ops of under 70 cycles plus the short tests fit with a wide margin
    localparam int    MAX_CYCLES = 20000;
    localparam int    WAIT_LIMIT = 200;
    localparam xlen_t MIN_NEG    = 64'h8000_0000_0000_0000;
    localparam xlen_t MAX_POS    = 64'h7fff_ffff_ffff_ffff;
    localparam xlen_t ALL_ONES   = 64'hffff_ffff_ffff_ffff;

    logic    clk;
    logic    rst;
    logic    flush;
    xlen_t   pc;
    xlen_t   rs1;
    xlen_t   rs2;
    xlen_t   csr;
    xlen_t   imm;
    alu_op_t operate;
    sel_a_t  sel_a;
    sel_b_t  sel_b;
    logic    rs1to32;
    xlen_t   res;
    logic    alu_wait;

    int      errors;
    int      cycles;
    int      seed;
    xlen_t   last_exp;

    exu_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .csr      (csr),
        .imm      (imm),
        .operate  (operate),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .rs1to32  (rs1to32),
        .res      (res),
        .alu_wait (alu_wait)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", MAX_CYCLES);
            $display("errors: %0d", errors + 1);
            $display("Test failed");
            $finish;
        end
    end

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // expected result straight from the operation rules
    function automatic xlen_t ref_result(alu_op_t op, xlen_t x, xlen_t y, logic w32);
        int    sh;
        logic  lt_s;
        xlen_t x_s;
        xlen_t t;
        sh   = int'(y[5:0]);
        lt_s = (x[63] != y[63]) ? x[63] : (x < y);
        x_s  = w32 ? {{32{x[31]}}, x[31:0]} : x;
        t    = (x_s >> sh) | (x_s[63] ? ~(ALL_ONES >> sh) : 64'h0);
        case (op)
            ALU_ADD:      return x + y;
            ALU_SUB:      return x - y;
            ALU_RETURN_A: return x;
            ALU_RETURN_B: return y;
            ALU_XOR:      return x ^ y;
            ALU_OR:       return x | y;
            ALU_AND:      return x & y;
            ALU_SLL:      return x << sh;
            ALU_SRL:      return x >> sh;
            ALU_SRA:      return w32 ? {32'b0, t[31:0]} : t;
            ALU_SLT:      return {63'b0, lt_s};
            ALU_SLTU:     return {63'b0, x < y};
            ALU_EQ:       return {63'b0, x == y};
            ALU_LOE:      return {63'b0, !lt_s};
            ALU_LOEU:     return {63'b0, !(x < y)};
            ALU_MUL:      return x * y;
            ALU_DIVU:     return (y == 0) ? ALL_ONES : x / y;
            ALU_REMU:     return (y == 0) ? x : x % y;
            ALU_DIV: begin
                if (y == 0) return ALL_ONES;
                if (x == MIN_NEG && y == ALL_ONES) return x;
                return $signed(x) / $signed(y);
            end
            ALU_REM: begin
                if (y == 0) return x;
                if (x == MIN_NEG && y == ALL_ONES) return 64'h0;
                return $signed(x) % $signed(y);
            end
            default:      return 64'h0;
        endcase
    endfunction

    task automatic check_res(input xlen_t exp_val);
        assert (res === exp_val) else begin
            errors++;
            $display("Mismatch res: expected %h, actual %h", exp_val, res);
        end
    endtask

    // starts and returns on a falling edge once res is checked
    task automatic exec_op(input alu_op_t op, input sel_a_t sa, input sel_b_t sb,
                           input logic w32, input xlen_t p, input xlen_t r1,
                           input xlen_t r2, input xlen_t c, input xlen_t i);
        xlen_t a_exp;
        xlen_t b_exp;
        xlen_t exp_res;
        logic  long_op;
        int    n;
        a_exp   = (sa == SEL_A_RS1) ? (w32 ? {32'b0, r1[31:0]} : r1) : p;
        b_exp   = (sb == SEL_B_RS2) ? r2 : ((sb == SEL_B_CSR) ? c : i);
        exp_res = ref_result(op, a_exp, b_exp, w32);
        long_op = op inside {ALU_MUL, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
        operate = op;
        sel_a   = sa;
        sel_b   = sb;
        rs1to32 = w32;
        pc      = p;
        rs1     = r1;
        rs2     = r2;
        csr     = c;
        imm     = i;
        #1;
        n = 0;
        while (alu_wait && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (n < WAIT_LIMIT) else begin
            errors++;
            $display("alu_wait stuck high for operation code %0d", op);
        end
        if (long_op) begin
            assert (n > 0) else begin
                errors++;
                $display("alu_wait never rose for long operation code %0d", op);
            end
        end else begin
            assert (n == 0) else begin
                errors++;
                $display("alu_wait rose for single-cycle operation code %0d", op);
            end
        end
        @(negedge clk);
        check_res(exp_res);
        last_exp = exp_res;
    endtask

    task automatic run_rr(input alu_op_t op, input xlen_t x, input xlen_t y);
        exec_op(op, SEL_A_RS1, SEL_B_RS2, 1'b0, 64'h1000, x, y, 64'hc5c5, 64'h7f);
    endtask

    task automatic reset_values();
        assert (!alu_wait) else begin
            errors++;
            $display("alu_wait is high right after reset");
        end
        check_res(64'h0);
    endtask

    task automatic single_cycle_ops();
        alu_op_t ops[15];
        xlen_t   ea[7];
        xlen_t   eb[7];
        ops = '{ALU_ADD, ALU_SUB, ALU_RETURN_A, ALU_RETURN_B, ALU_XOR, ALU_OR, ALU_AND,
                ALU_SLL, ALU_SRL, ALU_SLT, ALU_SLTU, ALU_SRA, ALU_EQ, ALU_LOE, ALU_LOEU};
        ea  = '{MIN_NEG, MAX_POS, 64'h0, ALL_ONES, MIN_NEG, 64'h0123_4567_89ab_cdef,
                64'hfedc_ba98_7654_3210};
        eb  = '{MAX_POS, MIN_NEG, ALL_ONES, 64'h0, 64'h3f, 64'h0123_4567_89ab_cdef, 64'h40};
        foreach (ops[k]) begin
            for (int j = 0; j < 4; j++) begin
                run_rr(ops[k], rand64(), rand64());
            end
            foreach (ea[j]) begin
                run_rr(ops[k], ea[j], eb[j]);
            end
        end
        // code outside the list
        run_rr(alu_op_t'(5'd25), rand64(), rand64());
    endtask

    task automatic operand_select();
        xlen_t p;
        xlen_t r1;
        xlen_t r2;
        xlen_t c;
        xlen_t i;
        p  = rand64();
        r1 = 64'h8000_1234_9abc_def0;
        r2 = rand64();
        c  = rand64();
        i  = rand64();
        exec_op(ALU_RETURN_A, SEL_A_RS1, SEL_B_RS2, 1'b0, p, r1, r2, c, i);
        exec_op(ALU_RETURN_A, SEL_A_PC, SEL_B_RS2, 1'b0, p, r1, r2, c, i);
        exec_op(ALU_RETURN_A, sel_a_t'(2'd3), SEL_B_RS2, 1'b0, p, r1, r2, c, i);
        exec_op(ALU_RETURN_B, SEL_A_RS1, SEL_B_RS2, 1'b0, p, r1, r2, c, i);
        exec_op(ALU_RETURN_B, SEL_A_RS1, SEL_B_CSR, 1'b0, p, r1, r2, c, i);
        exec_op(ALU_RETURN_B, SEL_A_RS1, SEL_B_IMM, 1'b0, p, r1, r2, c, i);
        exec_op(ALU_RETURN_B, SEL_A_RS1, sel_b_t'(2'd3), 1'b0, p, r1, r2, c, i);
        exec_op(ALU_RETURN_A, SEL_A_RS1, SEL_B_RS2, 1'b1, p, r1, r2, c, i);
        exec_op(ALU_RETURN_A, SEL_A_PC, SEL_B_RS2, 1'b1, p, r1, r2, c, i);
        // sra on a low word with bit 31 set
        exec_op(ALU_SRA, SEL_A_RS1, SEL_B_IMM, 1'b0, p, 64'h1234_5678_8765_4321, r2, c, 64'd4);
        exec_op(ALU_SRA, SEL_A_RS1, SEL_B_IMM, 1'b1, p, 64'h1234_5678_8765_4321, r2, c, 64'd4);
        exec_op(ALU_SRA, SEL_A_RS1, SEL_B_IMM, 1'b1, p, 64'h1234_5678_8765_4321, r2, c, 64'd36);
    endtask

    task automatic multiply_ops();
        xlen_t ma[7];
        xlen_t mb[7];
        ma = '{64'h0, 64'h1, ALL_ONES, ALL_ONES, MAX_POS, MIN_NEG, 64'hdead_beef_cafe_f00d};
        mb = '{rand64(), rand64(), ALL_ONES, 64'h3, MAX_POS, 64'h2, 64'hf00d_cafe_beef_dead};
        foreach (ma[j]) begin
            run_rr(ALU_MUL, ma[j], mb[j]);
        end
        for (int j = 0; j < 6; j++) begin
            run_rr(ALU_MUL, rand64(), rand64());
        end
    endtask

    // each op goes out on the falling edge right after the previous result
    task automatic divide_ops();
        alu_op_t ops[4];
        ops = '{ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
        foreach (ops[k]) begin
            for (int j = 0; j < 3; j++) begin
                run_rr(ops[k], rand64(), rand64());
                run_rr(ops[k], rand64(), rand64() >> 40);
            end
            run_rr(ops[k], rand64(), 64'h0);
            run_rr(ops[k], MIN_NEG, ALL_ONES);
            run_rr(ops[k], 64'hffff_ffff_ffff_fff9, 64'h2);
            run_rr(ops[k], 64'h7, 64'hffff_ffff_ffff_fffe);
        end
    endtask

    task automatic flush_abort();
        operate = ALU_DIV;
        sel_a   = SEL_A_RS1;
        sel_b   = SEL_B_RS2;
        rs1to32 = 1'b0;
        rs1     = rand64();
        rs2     = 64'd3;
        repeat (20) @(negedge clk);
        assert (alu_wait) else begin
            errors++;
            $display("alu_wait dropped before the flush was applied");
        end
        flush = 1'b1;
        @(negedge clk);
        assert (!alu_wait) else begin
            errors++;
            $display("alu_wait still high after the flush edge");
        end
        check_res(last_exp);
        flush = 1'b0;
        run_rr(ALU_DIVU, rand64(), 64'd12345);
        run_rr(ALU_MUL, rand64(), rand64());
    endtask

    initial begin
        seed     = 32'h34e2c9a6;
        errors   = 0;
        cycles   = 0;
        last_exp = '0;
        clk      = 1'b0;
        rst      = 1'b1;
        flush    = 1'b0;
        pc       = '0;
        rs1      = '0;
        rs2      = '0;
        csr      = '0;
        imm      = '0;
        operate  = ALU_ADD;
        sel_a    = SEL_A_RS1;
        sel_b    = SEL_B_RS2;
        rs1to32  = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_values();
        single_cycle_ops();
        operand_select();
        multiply_ops();
        divide_ops();
        flush_abort();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
common/alu_op_pkg.sv
common/exu_pkg.sv
hw/alu/mul_iter.sv
hw/alu/div_iter.sv
hw/alu/alu_core.sv
hw/exu_top.sv
tb/tb_exu.sv

// File: Bender.yml
package:
  name: exu

sources:
  # packages first, the request struct uses the operation enums
  - common/alu_op_pkg.sv
  - common/exu_pkg.sv
  - hw/alu/mul_iter.sv
  - hw/alu/div_iter.sv
  - hw/alu/alu_core.sv
  - hw/exu_top.sv
  - target: simulation
    files:
      - tb/tb_exu.sv
